// File: Makefile
VERILATOR ?= verilator
TOP       ?= mem_stage_tb
RTL_TOP   ?= mem_stage
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

RTL_SRCS := $(filter rtl/%,$(shell cat $(FILELIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: rtl/load_extend.sv
`timescale 1ns/1ns

module load_extend
    import mem_stage_pkg::*;
(
    input  logic [xlen-1:0] load_word,
    input  logic [2:0]      offset,
    mem_req_if.result_mp    req,
    output logic [xlen-1:0] mem_out
);

    logic [xlen-1:0] shifted;

    assign shifted = load_word >> {offset, 3'b000}; // addressed byte down to lane 0

    always_comb begin
        case (req.size)
            size_b: begin
                if (req.is_signed) begin
                    mem_out = {{(xlen-8){shifted[7]}}, shifted[7:0]};
                end else begin
                    mem_out = {{(xlen-8){1'b0}}, shifted[7:0]};
                end
            end
            size_h: begin
                if (req.is_signed) begin
                    mem_out = {{(xlen-16){shifted[15]}}, shifted[15:0]};
                end else begin
                    mem_out = {{(xlen-16){1'b0}}, shifted[15:0]};
                end
            end
            size_w: begin
                if (req.is_signed) begin
                    mem_out = {{(xlen-32){shifted[31]}}, shifted[31:0]};
                end else begin
                    mem_out = {{(xlen-32){1'b0}}, shifted[31:0]};
                end
            end
            default: begin
                mem_out = shifted; // full doubleword
            end
        endcase
    end

endmodule

// File: rtl/mem_bus_fsm.sv
`timescale 1ns/1ns

module mem_bus_fsm
    import mem_stage_pkg::*;
#(
    parameter int addr_w = addr_w_default
) (
    input  logic              clk,
    input  logic              rst,

    input  logic [addr_w-1:0] addr,
    input  logic [xlen-1:0]   store_data,
    mem_req_if.bus_mp         req,

    output logic              awvalid,
    input  logic              awready,
    output logic [addr_w-1:0] awaddr,
    output logic [2:0]        awsize,

    output logic              wvalid,
    input  logic              wready,
    output logic [xlen-1:0]   wdata,
    output logic [strb_w-1:0] wstrb,
    output logic              wlast,

    input  logic              bvalid,
    output logic              bready,

    output logic              arvalid,
    input  logic              arready,
    output logic [addr_w-1:0] araddr,
    output logic [2:0]        arsize,

    input  logic              rvalid,
    output logic              rready,
    input  logic [xlen-1:0]   rdata,

    output logic [xlen-1:0]   load_word,
    output logic              valid_out,
    output logic              mem_ok
);

    bus_state_e         state;
    bus_state_e         state_next;
    logic [2:0]         offset;
    logic [strb_w-1:0]  size_strb;

    assign offset = addr[2:0];

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (req.go) begin
                    state_next = req.is_store ? st_aw : st_ar;
                end
            end
            st_aw: begin
                if (awready) state_next = st_w;
            end
            st_w: begin
                if (wready) state_next = st_b;
            end
            st_b: begin
                if (bvalid) state_next = st_done;
            end
            st_ar: begin
                if (arready) state_next = st_r;
            end
            st_r: begin
                if (rvalid) state_next = st_done;
            end
            st_done: state_next = st_idle;
            default: state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            load_word <= '0;
        end else if (rvalid && rready) begin
            load_word <= rdata; // whole doubleword, lanes picked later
        end
    end

    // single-beat transfers, one channel active per state
    assign awvalid = (state == st_aw);
    assign wvalid  = (state == st_w);
    assign wlast   = wvalid;
    assign bready  = (state == st_b);
    assign arvalid = (state == st_ar);
    assign rready  = (state == st_r);

    assign awaddr = addr;
    assign araddr = addr;
    assign awsize = req.size;
    assign arsize = req.size;

    always_comb begin
        case (req.size)
            size_h:  size_strb = 8'h03;
            size_w:  size_strb = 8'h0f;
            size_d:  size_strb = 8'hff;
            default: size_strb = 8'h01;
        endcase
    end

    // store data moved up onto the lanes of its byte offset
    assign wdata = store_data << {offset, 3'b000};
    assign wstrb = size_strb << offset;

    // skipped requests finish in the idle cycle they arrive in
    assign valid_out = (state == st_idle && req.skip) || state == st_done;
    assign mem_ok    = (state == st_idle && !req.go) || state == st_done;

endmodule

// File: rtl/mem_op_decode.sv
`timescale 1ns/1ns

module mem_op_decode
    import mem_stage_pkg::*;
(
    input  logic      valid_in,
    input  mem_op_e   op,
    input  logic [2:0] offset,
    input  trap_t     trap_in,
    output trap_t     trap_out,
    mem_req_if.decode_mp req
);

    logic         is_load;
    logic         is_store;
    logic         is_signed;
    access_size_e size;
    logic [2:0]   align_mask;
    logic         misaligned;

    always_comb begin
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_signed = 1'b0;
        size      = size_b;
        case (op)
            op_lb:  begin is_load = 1'b1; is_signed = 1'b1; size = size_b; end
            op_lh:  begin is_load = 1'b1; is_signed = 1'b1; size = size_h; end
            op_lw:  begin is_load = 1'b1; is_signed = 1'b1; size = size_w; end
            op_ld:  begin is_load = 1'b1; is_signed = 1'b1; size = size_d; end
            op_lbu: begin is_load = 1'b1; size = size_b; end
            op_lhu: begin is_load = 1'b1; size = size_h; end
            op_lwu: begin is_load = 1'b1; size = size_w; end
            op_sb:  begin is_store = 1'b1; size = size_b; end
            op_sh:  begin is_store = 1'b1; size = size_h; end
            op_sw:  begin is_store = 1'b1; size = size_w; end
            op_sd:  begin is_store = 1'b1; size = size_d; end
            default: begin
                size = size_b; // nop and unused codes
            end
        endcase
    end

    // low offset bits that have to be zero for a naturally aligned access
    always_comb begin
        case (size)
            size_h:  align_mask = 3'b001;
            size_w:  align_mask = 3'b011;
            size_d:  align_mask = 3'b111;
            default: align_mask = 3'b000;
        endcase
    end

    assign misaligned = |(offset & align_mask);

    // an older trap always wins over a misaligned access
    always_comb begin
        trap_out = trap_in;
        if (valid_in && trap_in == trap_none && misaligned) begin
            if (is_load) begin
                trap_out = trap_load_misalign;
            end else if (is_store) begin
                trap_out = trap_store_misalign;
            end
        end
    end

    assign req.go        = valid_in && (is_load || is_store) && trap_out == trap_none;
    assign req.skip      = valid_in && !req.go;
    assign req.is_store  = is_store;
    assign req.size      = size;
    assign req.is_signed = is_signed;

endmodule

// File: rtl/mem_req_if.sv
`timescale 1ns/1ns

interface mem_req_if
    import mem_stage_pkg::*;
();

    logic         go;        // load or store that goes out on the bus
    logic         skip;      // valid but finishes without a bus access
    logic         is_store;
    access_size_e size;
    logic         is_signed;

    modport decode_mp (
        output go, skip, is_store, size, is_signed
    );

    modport bus_mp (
        input go, skip, is_store, size
    );

    modport result_mp (
        input size, is_signed
    );

endinterface

// File: rtl/mem_stage.sv
`timescale 1ns/1ns

module mem_stage
    import mem_stage_pkg::*;
#(
    parameter int addr_w = addr_w_default
) (
    input  logic              clk,
    input  logic              rst,

    input  logic              valid_in,
    input  mem_op_e           op,
    input  logic [addr_w-1:0] addr,
    input  logic [xlen-1:0]   store_data,
    input  trap_t             trap_in,

    output logic              mem_ok,
    output logic              valid_out,
    output logic [xlen-1:0]   mem_out,
    output trap_t             trap_out,

    output logic              awvalid,
    input  logic              awready,
    output logic [addr_w-1:0] awaddr,
    output logic [2:0]        awsize,

    output logic              wvalid,
    input  logic              wready,
    output logic [xlen-1:0]   wdata,
    output logic [strb_w-1:0] wstrb,
    output logic              wlast,

    input  logic              bvalid,
    output logic              bready,

    output logic              arvalid,
    input  logic              arready,
    output logic [addr_w-1:0] araddr,
    output logic [2:0]        arsize,

    input  logic              rvalid,
    output logic              rready,
    input  logic [xlen-1:0]   rdata
);

    logic [xlen-1:0] load_word;

    mem_req_if req_if ();

    mem_op_decode i_mem_op_decode (
        .valid_in (valid_in),
        .op       (op),
        .offset   (addr[2:0]),
        .trap_in  (trap_in),
        .trap_out (trap_out),
        .req      (req_if.decode_mp)
    );

    mem_bus_fsm #(
        .addr_w (addr_w)
    ) i_mem_bus_fsm (
        .clk        (clk),
        .rst        (rst),
        .addr       (addr),
        .store_data (store_data),
        .req        (req_if.bus_mp),
        .awvalid    (awvalid),
        .awready    (awready),
        .awaddr     (awaddr),
        .awsize     (awsize),
        .wvalid     (wvalid),
        .wready     (wready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wlast      (wlast),
        .bvalid     (bvalid),
        .bready     (bready),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .arsize     (arsize),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .load_word  (load_word),
        .valid_out  (valid_out),
        .mem_ok     (mem_ok)
    );

    load_extend i_load_extend (
        .load_word (load_word),
        .offset    (addr[2:0]),
        .req       (req_if.result_mp),
        .mem_out   (mem_out)
    );

endmodule

// File: rtl/mem_stage_pkg.sv
package mem_stage_pkg;

    localparam int xlen           = 64;
    localparam int strb_w         = xlen / 8;
    localparam int addr_w_default = 32;

    // memory opcode from the execute stage
    typedef enum logic [3:0] {
        op_nop = 4'd0,
        op_lb  = 4'd1,
        op_lh  = 4'd2,
        op_lw  = 4'd3,
        op_ld  = 4'd4,
        op_lbu = 4'd5,
        op_lhu = 4'd6,
        op_lwu = 4'd7,
        op_sb  = 4'd8,
        op_sh  = 4'd9,
        op_sw  = 4'd10,
        op_sd  = 4'd11
    } mem_op_e;

    // same encoding as axsize
    typedef enum logic [2:0] {
        size_b = 3'd0,
        size_h = 3'd1,
        size_w = 3'd2,
        size_d = 3'd3
    } access_size_e;

    typedef logic [3:0] trap_t;

    localparam trap_t trap_none           = 4'd0;
    localparam trap_t trap_load_misalign  = 4'd4;
    localparam trap_t trap_store_misalign = 4'd6;

    typedef enum logic [2:0] {
        st_idle = 3'd0,
        st_aw   = 3'd1,
        st_w    = 3'd2,
        st_b    = 3'd3,
        st_ar   = 3'd4,
        st_r    = 3'd5,
        st_done = 3'd6
    } bus_state_e;

endpackage

// File: src.f
rtl/mem_stage_pkg.sv
rtl/mem_req_if.sv
rtl/mem_op_decode.sv
rtl/mem_bus_fsm.sv
rtl/load_extend.sv
rtl/mem_stage.sv
verif/mem_stage_assert.sv
verif/mem_stage_tb.sv

// File: verif/mem_stage_assert.sv
`timescale 1ns/1ns

module mem_stage_assert
    import mem_stage_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       awvalid,
    input logic       awready,
    input logic       wvalid,
    input logic       wready,
    input logic       arvalid,
    input logic       arready,
    input logic       valid_out,
    input logic [2:0] state
);

    // a valid without its ready must still be there one cycle later
    aw_hold: assert property (@(posedge clk) disable iff (rst) awvalid && !awready |=> awvalid)
        else $error("awvalid dropped before awready");
    w_hold: assert property (@(posedge clk) disable iff (rst) wvalid && !wready |=> wvalid)
        else $error("wvalid dropped before wready");
    ar_hold: assert property (@(posedge clk) disable iff (rst) arvalid && !arready |=> arvalid)
        else $error("arvalid dropped before arready");

    valid_out_pulse: assert property (@(posedge clk) disable iff (rst) valid_out |=> !valid_out)
        else $error("valid_out high for more than one cycle");

    state_legal: assert property (@(posedge clk) disable iff (rst)
        state inside {st_idle, st_aw, st_w, st_b, st_ar, st_r, st_done})
        else $error("bus fsm state out of range");

endmodule

bind mem_bus_fsm mem_stage_assert i_mem_stage_assert (
    .clk       (clk),
    .rst       (rst),
    .awvalid   (awvalid),
    .awready   (awready),
    .wvalid    (wvalid),
    .wready    (wready),
    .arvalid   (arvalid),
    .arready   (arready),
    .valid_out (valid_out),
    .state     (state)
);

// File: verif/mem_stage_tb.sv
`timescale 1ns/1ns

module mem_stage_tb
    import mem_stage_pkg::*;
();

    localparam int addr_w     = 32;
    localparam int wait_limit = 40;

    logic              clk;
    logic              rst;
    logic              valid_in;
    mem_op_e           op;
    logic [addr_w-1:0] addr;
    logic [xlen-1:0]   store_data;
    trap_t             trap_in;
    logic              mem_ok;
    logic              valid_out;
    logic [xlen-1:0]   mem_out;
    trap_t             trap_out;
    logic              awvalid, wvalid, wlast, bready, arvalid, rready;
    logic [addr_w-1:0] awaddr, araddr;
    logic [2:0]        awsize, arsize;
    logic [xlen-1:0]   wdata;
    logic [strb_w-1:0] wstrb;
    logic              awready = 1'b0;
    logic              wready  = 1'b0;
    logic              bvalid  = 1'b0;
    logic              arready = 1'b0;
    logic              rvalid  = 1'b0;
    logic [xlen-1:0]   rdata   = '0;

    logic [xlen-1:0] slave_mem [64];
    logic [xlen-1:0] shadow_mem [64];  // expected memory contents
    int              aw_cnt, w_cnt, b_cnt, ar_cnt, r_cnt;
    logic            b_pend, r_pend;
    logic [5:0]      wr_index;
    int              xfers = 0;
    logic            random_delays;

    logic [xlen-1:0]   exp_out;
    trap_t             exp_trap;
    int                exp_xfers;
    logic [addr_w-1:0] exp_addr;
    logic [2:0]        exp_size;
    int                xfers_at_issue;
    logic              pending;
    logic              after_reset = 1'b0;
    int                checks = 0;
    int                errors = 0;
    int                tests = 0;
    int                checks_at_start, errors_at_start;
    string             test_name;

    mem_stage #(
        .addr_w (addr_w)
    ) i_mem_stage (
        .clk (clk), .rst (rst), .valid_in (valid_in), .op (op), .addr (addr),
        .store_data (store_data), .trap_in (trap_in), .mem_ok (mem_ok),
        .valid_out (valid_out), .mem_out (mem_out), .trap_out (trap_out),
        .awvalid (awvalid), .awready (awready), .awaddr (awaddr), .awsize (awsize),
        .wvalid (wvalid), .wready (wready), .wdata (wdata), .wstrb (wstrb), .wlast (wlast),
        .bvalid (bvalid), .bready (bready),
        .arvalid (arvalid), .arready (arready), .araddr (araddr), .arsize (arsize),
        .rvalid (rvalid), .rready (rready), .rdata (rdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [xlen-1:0] fill_word(input int index);
        logic [xlen-1:0] w;
        for (int b = 0; b < 8; b++) begin
            w[b * 8 +: 8] = 8'(((index * 8 + b) * 29) ^ (index >> 2)); // whole byte address
        end
        return w;
    endfunction

    function automatic int pick_delay();
        return random_delays ? int'($urandom % 4) : 0;
    endfunction

    function automatic int op_bytes(input mem_op_e o);
        case (o)
            op_lb, op_lbu, op_sb: return 1;
            op_lh, op_lhu, op_sh: return 2;
            op_lw, op_lwu, op_sw: return 4;
            op_ld, op_sd:         return 8;
            default:              return 0;
        endcase
    endfunction

    function automatic logic [2:0] aligned_offset(input mem_op_e o);
        int n;
        n = (op_bytes(o) == 0) ? 1 : op_bytes(o);
        return 3'((int'($urandom % 8) / n) * n);
    endfunction

    // expected result, trap and number of AXI transfers for one request
    function automatic void reference_model(input mem_op_e o, input logic [2:0] off,
                                            input trap_t tin, input logic [xlen-1:0] dword,
                                            output logic [xlen-1:0] out_v,
                                            output trap_t trap_v, output int xfers_v);
        int              n;
        logic [xlen-1:0] shifted;
        logic [xlen-1:0] mask;
        n = op_bytes(o);
        out_v = '0;
        trap_v = tin;
        xfers_v = 0;
        if (tin != trap_none || n == 0) return;
        if (int'(off) % n != 0) begin
            trap_v = (o inside {op_sb, op_sh, op_sw, op_sd}) ? trap_store_misalign
                                                             : trap_load_misalign;
            return;
        end
        if (o inside {op_sb, op_sh, op_sw, op_sd}) begin
            xfers_v = 3; // aw, w, b
            return;
        end
        xfers_v = 2;
        shifted = dword >> (8 * int'(off));
        mask = (n == 8) ? '1 : (64'd1 << (8 * n)) - 64'd1;
        out_v = shifted & mask;
        if ((o inside {op_lb, op_lh, op_lw}) && n < 8 && shifted[8 * n - 1]) begin
            out_v = out_v | ~mask;
        end
    endfunction

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s: actual %h expected %h at %0t",
                     name, actual, expected, $time);
        end
    endtask

    // AXI slave memory with ready and valid delays picked per transfer
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            awready <= 1'b0;
            wready <= 1'b0;
            bvalid <= 1'b0;
            arready <= 1'b0;
            rvalid <= 1'b0;
            rdata <= '0;
            aw_cnt <= 0;
            w_cnt <= 0;
            b_cnt <= 0;
            ar_cnt <= 0;
            r_cnt <= 0;
            b_pend <= 1'b0;
            r_pend <= 1'b0;
            wr_index <= '0;
            for (int i = 0; i < 64; i++) begin
                slave_mem[i] <= fill_word(i);
            end
        end else begin
            if (awvalid && awready) begin
                awready <= 1'b0;
                wr_index <= awaddr[8:3];
                aw_cnt <= pick_delay();
                xfers++;
            end else if (awvalid) begin
                if (aw_cnt == 0) awready <= 1'b1;
                else aw_cnt <= aw_cnt - 1;
            end
            if (wvalid && wready) begin
                wready <= 1'b0;
                w_cnt <= pick_delay();
                for (int b = 0; b < strb_w; b++) begin
                    if (wstrb[b]) slave_mem[wr_index][b * 8 +: 8] <= wdata[b * 8 +: 8];
                end
                b_pend <= 1'b1;
                b_cnt <= pick_delay();
                xfers++;
            end else if (wvalid) begin
                if (w_cnt == 0) wready <= 1'b1;
                else w_cnt <= w_cnt - 1;
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
                xfers++;
            end else if (b_pend) begin
                if (b_cnt == 0) begin
                    bvalid <= 1'b1;
                    b_pend <= 1'b0;
                end else begin
                    b_cnt <= b_cnt - 1;
                end
            end
            if (arvalid && arready) begin
                arready <= 1'b0;
                ar_cnt <= pick_delay();
                rdata <= slave_mem[araddr[8:3]]; // whole doubleword
                r_pend <= 1'b1;
                r_cnt <= pick_delay();
                xfers++;
            end else if (arvalid) begin
                if (ar_cnt == 0) arready <= 1'b1;
                else ar_cnt <= ar_cnt - 1;
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
                xfers++;
            end else if (r_pend) begin
                if (r_cnt == 0) begin
                    rvalid <= 1'b1;
                    r_pend <= 1'b0;
                end else begin
                    r_cnt <= r_cnt - 1;
                end
            end
        end
    end

    // compare process samples the settled outputs at the falling edge
    always @(negedge clk) begin
        if (rst) begin
            after_reset = 1'b1;
        end else begin
            if (after_reset) begin
                after_reset = 1'b0;
                check_value("awvalid wvalid bready arvalid rready",
                            64'({awvalid, wvalid, bready, arvalid, rready}), 64'd0);
                check_value("valid_out", 64'(valid_out), 64'd0);
                check_value("mem_ok", 64'(mem_ok), 64'd1);
            end
            if (pending) begin
                check_value("mem_ok", 64'(mem_ok), 64'(valid_out)); // busy until the end
                if (exp_xfers == 0) begin
                    check_value("valid_out", 64'(valid_out), 64'd1);
                    check_value("awvalid wvalid arvalid", 64'({awvalid, wvalid, arvalid}), 64'd0);
                end
                if (awvalid) begin
                    check_value("awaddr", 64'(awaddr), 64'(exp_addr));
                    check_value("awsize", 64'(awsize), 64'(exp_size));
                end
                if (wvalid) check_value("wlast", 64'(wlast), 64'd1);
                if (arvalid) begin
                    check_value("araddr", 64'(araddr), 64'(exp_addr));
                    check_value("arsize", 64'(arsize), 64'(exp_size));
                end
                if (valid_out) begin
                    check_value("trap_out", 64'(trap_out), 64'(exp_trap));
                    if (exp_xfers == 2) check_value("mem_out", mem_out, exp_out);
                    check_value("bus transfers", 64'(xfers - xfers_at_issue), 64'(exp_xfers));
                end
            end else if (valid_out) begin
                errors++;
                $display("valid_out went high with no request outstanding at %0t", $time);
            end
        end
    end

    task automatic do_access(input mem_op_e o, input logic [5:0] idx, input logic [2:0] off,
                             input logic [xlen-1:0] data, input trap_t tin);
        int waited;
        reference_model(o, off, tin, shadow_mem[idx], exp_out, exp_trap, exp_xfers);
        exp_addr = 32'h8000_0000 | {23'd0, idx, off};
        exp_size = 3'($clog2(op_bytes(o))); // log2 of the byte count
        xfers_at_issue = xfers;
        @(posedge clk);
        valid_in <= 1'b1;
        op <= o;
        addr <= exp_addr;
        store_data <= data;
        trap_in <= tin;
        pending = 1'b1;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > wait_limit) begin
                $display("timeout: %s got no valid_out within %0d cycles", o.name(), wait_limit);
                $display("Simulation finished: FAIL");
                $finish;
            end
        end while (!valid_out);
        @(posedge clk);
        valid_in <= 1'b0;
        pending = 1'b0;
        if (exp_xfers == 3) begin
            for (int b = 0; b < op_bytes(o); b++) begin
                shadow_mem[idx][(int'(off) + b) * 8 +: 8] = data[b * 8 +: 8];
            end
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        checks_at_start = checks;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        tests++;
        $display("test %-16s %0d checks, %0d errors", test_name,
                 checks - checks_at_start, errors - errors_at_start);
    endtask

    initial begin
        mem_op_e    o;
        logic [5:0] idx;
        mem_op_e    store_ops [4];
        mem_op_e    load_ops [7];
        mem_op_e    sized_ops [8];
        void'($urandom(32'h9509_ea79));
        store_ops = '{op_sb, op_sh, op_sw, op_sd};
        load_ops = '{op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu};
        sized_ops = '{op_lh, op_lw, op_ld, op_lhu, op_lwu, op_sh, op_sw, op_sd};
        rst = 1'b1;
        valid_in = 1'b0;
        op = op_nop;
        addr = '0;
        store_data = '0;
        trap_in = trap_none;
        random_delays = 1'b0;
        pending = 1'b0;
        exp_out = '0;
        exp_trap = trap_none;
        exp_xfers = 0;
        exp_addr = '0;
        exp_size = '0;
        xfers_at_issue = 0;
        for (int i = 0; i < 64; i++) begin
            shadow_mem[i] = fill_word(i);
        end

        start_test("reset");
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        end_test();

        start_test("store_then_load");
        for (int k = 0; k < 4; k++) begin
            repeat (3) begin
                idx = 6'($urandom);
                do_access(store_ops[k], idx, aligned_offset(store_ops[k]),
                          {$urandom, $urandom}, trap_none);
                do_access(op_ld, idx, 3'd0, '0, trap_none);
            end
        end
        end_test();

        start_test("load_ops");
        for (int k = 0; k < 7; k++) begin
            repeat (4) do_access(load_ops[k], 6'($urandom), aligned_offset(load_ops[k]),
                                 '0, trap_none);
        end
        end_test();

        start_test("misaligned");
        for (int k = 0; k < 16; k++) begin
            o = sized_ops[k % 8];
            do_access(o, 6'($urandom), aligned_offset(o) | 3'd1, {$urandom, $urandom}, trap_none);
        end
        end_test();

        start_test("trap_passthrough");
        repeat (12) begin
            o = mem_op_e'(4'($urandom % 12));
            do_access(o, 6'($urandom), 3'($urandom), {$urandom, $urandom},
                      trap_t'(4'(1 + $urandom % 15)));
        end
        repeat (3) do_access(op_nop, 6'($urandom), 3'($urandom), '0, trap_none);
        end_test();

        start_test("random_delays");
        random_delays = 1'b1;
        repeat (60) begin
            o = mem_op_e'(4'(1 + $urandom % 11));
            do_access(o, 6'($urandom), aligned_offset(o), {$urandom, $urandom}, trap_none);
        end
        for (int i = 0; i < 64; i++) begin
            do_access(op_ld, 6'(i), 3'd0, '0, trap_none); // sweep catches any stray write
        end
        end_test();

        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
